// ==== hdl/cheat_params.svh ====
/*
  Widths, APB register map and watchdog limit of the cheat engine.
  Register addresses are full 8-bit matches.
  The host address registers hold 24 bits. Only the low CHEAT_AW bits
  reach the SDRAM bank.
*/
`ifndef CHEAT_PARAMS_SVH
`define CHEAT_PARAMS_SVH

`define CHEAT_AW          22
`define CHEAT_DW          16
`define CHEAT_WDOG_FRAMES 8

`define REG_ADDR0  8'h00
`define REG_ADDR1  8'h01
`define REG_ADDR2  8'h02
`define REG_WDATA0 8'h03
`define REG_WDATA1 8'h04
`define REG_MASK   8'h05
`define REG_RDATA0 8'h06
`define REG_RDATA1 8'h07
`define REG_LED    8'h08
`define REG_FLAGS0 8'h10
`define REG_FLAGS1 8'h11
`define REG_FLAGS2 8'h12
`define REG_FLAGS3 8'h13
`define REG_KICK   8'h40
`define REG_RD_GO  8'h80
`define REG_WR_GO  8'hC0

`endif

// ==== hdl/cheat_pkg.sv ====
/*
  Shared types of the cheat engine.
  Bank request and response structs are used for the game port, the
  host port and the SDRAM bank port alike.
*/
`default_nettype none

`include "cheat_params.svh"

package cheat_pkg;

    typedef logic [`CHEAT_AW-1:0] sdram_addr_t;
    typedef logic [`CHEAT_DW-1:0] sdram_data_t;
    typedef logic [1:0]           sdram_mask_t;
    typedef logic [7:0]           port_data_t;
    typedef logic [7:0]           port_addr_t;

    // Held by the requester until ack
    typedef struct packed {
        sdram_addr_t addr;
        logic        rd;
        logic        wr;
        sdram_data_t din;
        sdram_mask_t din_m;
    } bank_req_t;

    // Single-cycle pulses from the bank
    typedef struct packed {
        logic ack;
        logic dst;
        logic rdy;
    } bank_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GAME,
        ARB_HOST
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/cheat_regs.sv ====
/*
  APB register file of the cheat engine.
  APB has no wait states and no error response; prdata is a plain mux.
  A start command written while the previous host transaction is busy
  is ignored. A watchdog trip drops the pending request, the busy flag
  and the LED. Read data is captured on dst of the host transaction.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cheat_params.svh"

module cheat_regs
    import cheat_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        prst,
    input  wire port_addr_t  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire port_data_t  pwdata,
    output port_data_t       prdata,
    input  wire logic [31:0] flags,
    input  wire logic        lvbl,
    input  wire logic        wdog_trip,
    input  wire bank_rsp_t   host_rsp,
    input  wire sdram_data_t data_read,
    output bank_req_t        host_req,
    output logic             led,
    output logic             kick
);

    port_data_t  addr_r [3];
    port_data_t  wdata_r [2];
    sdram_mask_t mask_r;
    sdram_data_t rdata_r;

    logic wr_en;
    logic go;
    logic pending;
    logic busy;
    logic is_wr;

    // APB write lands at the access phase edge
    assign wr_en = psel && penable && pwrite;
    assign kick  = wr_en && (paddr == `REG_KICK);
    assign go    = wr_en && !busy && (paddr == `REG_RD_GO || paddr == `REG_WR_GO);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr)
                `REG_ADDR0:  addr_r[0]  <= pwdata;
                `REG_ADDR1:  addr_r[1]  <= pwdata;
                `REG_ADDR2:  addr_r[2]  <= pwdata;
                `REG_WDATA0: wdata_r[0] <= pwdata;
                `REG_WDATA1: wdata_r[1] <= pwdata;
                `REG_MASK:   mask_r     <= pwdata[1:0];
                default: ;
            endcase
        end
        if (host_rsp.dst) begin
            rdata_r <= data_read;
        end
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            led     <= 1'b0;
            pending <= 1'b0;
            busy    <= 1'b0;
            is_wr   <= 1'b0;
        end else begin
            if (wr_en && paddr == `REG_LED) begin
                led <= pwdata[0];
            end
            if (host_rsp.ack) begin
                pending <= 1'b0;
            end
            if (host_rsp.rdy) begin
                busy <= 1'b0;
            end
            if (go) begin
                pending <= 1'b1;
                busy    <= 1'b1;
                is_wr   <= (paddr == `REG_WR_GO);
            end
            // Host went silent, drop what it left behind
            if (wdog_trip) begin
                led     <= 1'b0;
                pending <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

    always_comb begin
        host_req.addr  = sdram_addr_t'({addr_r[2], addr_r[1], addr_r[0]});
        host_req.rd    = pending && !is_wr;
        host_req.wr    = pending && is_wr;
        host_req.din   = {wdata_r[1], wdata_r[0]};
        host_req.din_m = mask_r;
    end

    // Read mux, valid whenever paddr is stable
    always_comb begin
        case (paddr)
            `REG_ADDR0:  prdata = addr_r[0];
            `REG_ADDR1:  prdata = addr_r[1];
            `REG_ADDR2:  prdata = addr_r[2];
            `REG_WDATA0: prdata = wdata_r[0];
            `REG_WDATA1: prdata = wdata_r[1];
            `REG_MASK:   prdata = {6'd0, mask_r};
            `REG_RDATA0: prdata = rdata_r[7:0];
            `REG_RDATA1: prdata = rdata_r[15:8];
            `REG_LED:    prdata = {7'd0, led};
            `REG_FLAGS0: prdata = flags[7:0];
            `REG_FLAGS1: prdata = flags[15:8];
            `REG_FLAGS2: prdata = flags[23:16];
            `REG_FLAGS3: prdata = flags[31:24];
            `REG_RD_GO:  prdata = {pending, busy, lvbl, 5'd0};
            default:     prdata = 8'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/vblank_watchdog.sv ====
/*
  Vertical blank watchdog.
  lvbl_in is registered once; it must already be in the clk domain.
  wdog_trip pulses on the blank start that completes CHEAT_WDOG_FRAMES
  frames without a kick. A kick in the same cycle wins.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cheat_params.svh"

module vblank_watchdog (
    input  wire logic clk,
    input  wire logic prst,
    input  wire logic lvbl_in,
    input  wire logic kick,
    output logic      lvbl,
    output logic      wdog_trip
);

    localparam int FW = $clog2(`CHEAT_WDOG_FRAMES + 1);

    logic          lvbl_last;
    logic          vbl_start;
    logic [FW-1:0] frames;

    always_ff @(posedge clk) begin
        if (prst) begin
            lvbl      <= 1'b1;
            lvbl_last <= 1'b1;
            vbl_start <= 1'b0;
            frames    <= '0;
        end else begin
            lvbl      <= lvbl_in;
            lvbl_last <= lvbl;
            // Falling edge of LVBL means blanking has begun
            vbl_start <= lvbl_last && !lvbl;
            if (kick || wdog_trip) begin
                frames <= '0;
            end else if (vbl_start) begin
                frames <= frames + 1'b1;
            end
        end
    end

    assign wdog_trip = vbl_start && !kick &&
                       (frames == FW'(`CHEAT_WDOG_FRAMES - 1));

endmodule

`default_nettype wire

// ==== hdl/sdram_arbiter.sv ====
/*
  Bank arbiter between the game and the host.
  The game wins when both request in the same idle cycle.
  One transaction per grant; the owner is released after bank rdy.
  If the owner withdraws its request before ack, the grant is released
  too, so a dropped host request cannot lock the bank.
*/
`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter
    import cheat_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      prst,
    input  wire bank_req_t game_req,
    input  wire bank_req_t host_req,
    input  wire bank_rsp_t bank_rsp,
    output bank_req_t      bank_req,
    output bank_rsp_t      game_rsp,
    output bank_rsp_t      host_rsp
);

    arb_state_t state;
    logic       acked;
    logic       owner_req;

    always_ff @(posedge clk) begin
        if (prst) begin
            state <= ARB_IDLE;
            acked <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    acked <= 1'b0;
                    if (game_req.rd || game_req.wr) begin
                        state <= ARB_GAME;
                    end else if (host_req.rd || host_req.wr) begin
                        state <= ARB_HOST;
                    end
                end
                default: begin
                    if (bank_rsp.ack) begin
                        acked <= 1'b1;
                    end
                    if (bank_rsp.rdy) begin
                        state <= ARB_IDLE;
                    end else if (!acked && !bank_rsp.ack && !owner_req) begin
                        // Request withdrawn before the bank took it
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // Owner's request goes to the bank, nobody's while idle
    always_comb begin
        bank_req = (state == ARB_HOST) ? host_req : game_req;
        if (state == ARB_IDLE) begin
            bank_req.rd = 1'b0;
            bank_req.wr = 1'b0;
        end
        owner_req = bank_req.rd || bank_req.wr;
    end

    // Responses reach the owner only
    always_comb begin
        game_rsp = (state == ARB_GAME) ? bank_rsp : '0;
        host_rsp = (state == ARB_HOST) ? bank_rsp : '0;
    end

endmodule

`default_nettype wire

// ==== hdl/cheat_top.sv ====
/*
  Cheat engine top level.
  One APB slave for the host, a game port and the SDRAM bank port.
  The game has priority on the bank. Latency of any bank access depends
  on the bank and on game traffic; a waiting requester keeps its request
  held. data_read goes straight to the game, which owns its filtering.
*/
`timescale 1ns/1ps
`default_nettype none

module cheat_top
    import cheat_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        prst,
    input  wire port_addr_t  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire port_data_t  pwdata,
    output port_data_t       prdata,
    input  wire logic        lvbl,
    input  wire logic [31:0] flags,
    output logic             led,
    input  wire bank_req_t   game_req,
    output bank_rsp_t        game_rsp,
    output bank_req_t        bank_req,
    input  wire bank_rsp_t   bank_rsp,
    input  wire sdram_data_t data_read
);

    bank_req_t host_req;
    bank_rsp_t host_rsp;
    logic      lvbl_sync;
    logic      kick;
    logic      wdog_trip;

    cheat_regs u_regs (
        .clk       (clk),
        .prst      (prst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .flags     (flags),
        .lvbl      (lvbl_sync),
        .wdog_trip (wdog_trip),
        .host_rsp  (host_rsp),
        .data_read (data_read),
        .host_req  (host_req),
        .led       (led),
        .kick      (kick)
    );

    vblank_watchdog u_wdog (
        .clk       (clk),
        .prst      (prst),
        .lvbl_in   (lvbl),
        .kick      (kick),
        .lvbl      (lvbl_sync),
        .wdog_trip (wdog_trip)
    );

    sdram_arbiter u_arb (
        .clk      (clk),
        .prst     (prst),
        .game_req (game_req),
        .host_req (host_req),
        .bank_rsp (bank_rsp),
        .bank_req (bank_req),
        .game_rsp (game_rsp),
        .host_rsp (host_rsp)
    );

endmodule

`default_nettype wire

// ==== test/cheat_properties.sv ====
/*
  Concurrent checks on the bank arbiter, bound into sdram_arbiter.
  Requires a simulator run with assertions enabled.
*/
`timescale 1ns/1ps
`default_nettype none

module cheat_properties
    import cheat_pkg::*;
(
    input wire logic      clk,
    input wire logic      prst,
    input wire arb_state_t state,
    input wire bank_req_t bank_req,
    input wire bank_rsp_t bank_rsp,
    input wire bank_rsp_t game_rsp,
    input wire bank_rsp_t host_rsp
);

    logic in_tx;

    // Bank transaction open from its ack up to its rdy
    always_ff @(posedge clk) begin
        if (prst) begin
            in_tx <= 1'b0;
        end else if (bank_rsp.rdy) begin
            in_tx <= 1'b0;
        end else if (bank_rsp.ack) begin
            in_tx <= 1'b1;
        end
    end

    no_rd_and_wr: assert property (@(posedge clk) disable iff (prst)
        !(bank_req.rd && bank_req.wr))
        else $error("bank saw rd and wr together");

    // Every bank response reaches exactly one side
    one_owner_rsp: assert property (@(posedge clk) disable iff (prst)
        (|bank_rsp) |-> ((|game_rsp) != (|host_rsp)))
        else $error("bank response lost or sent to both sides");

    // Once the bank has taken the request, the owner stays until rdy
    owner_held: assert property (@(posedge clk) disable iff (prst)
        (state != ARB_IDLE && (in_tx || bank_rsp.ack) && !bank_rsp.rdy)
        |=> state == $past(state))
        else $error("owner changed between grant and rdy");

endmodule

bind sdram_arbiter cheat_properties u_props (
    .clk(clk), .prst(prst), .state(state), .bank_req(bank_req),
    .bank_rsp(bank_rsp), .game_rsp(game_rsp), .host_rsp(host_rsp)
);

`default_nettype wire

// ==== test/cheat_tb.sv ====
/*
  Testbench for cheat_top with bank, game and blanking models.
  Game addresses keep bit 21 low and host addresses set it, so the
  expected memory contents stay simple. Bank mask bit i high writes byte i.
  Stops at the first error.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cheat_params.svh"

module cheat_tb
    import cheat_pkg::*;
;
    localparam int PERIOD    = 20;
    localparam int FRAME     = 40;
    localparam int N_REG     = 20;
    localparam int N_HOST    = 40;
    // Worst case per test, in cycles, including the watchdog frames
    localparam int WORST_TX  = 600;
    localparam int N_TESTS   = N_REG + N_HOST + 2;

    logic        clk;
    logic        prst;
    port_addr_t  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    port_data_t  pwdata;
    port_data_t  prdata;
    logic        lvbl;
    logic [31:0] flags;
    logic        led;
    bank_req_t   game_req = '0;
    bank_rsp_t   game_rsp;
    bank_req_t   bank_req;
    bank_rsp_t   bank_rsp = '0;
    sdram_data_t data_read = '0;

    integer      seed = 22887;
    sdram_data_t mem [sdram_addr_t];
    bit          seen_rd [sdram_addr_t];
    logic        game_en = 1'b0;
    logic        bank_hold = 1'b0;

    cheat_top uut (
        .clk(clk), .prst(prst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .lvbl(lvbl),
        .flags(flags), .led(led), .game_req(game_req), .game_rsp(game_rsp),
        .bank_req(bank_req), .bank_rsp(bank_rsp), .data_read(data_read)
    );

    task automatic fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    // Power-up content, a function of the whole address
    function automatic sdram_data_t mem_read(input sdram_addr_t a);
        sdram_data_t fill;
        fill = a[15:0] ^ a[21:6] ^ 16'h5a3c;
        return mem.exists(a) ? mem[a] : fill;
    endfunction

    function automatic sdram_data_t merge(input sdram_data_t old, input sdram_data_t d,
                                          input sdram_mask_t m);
        return {m[1] ? d[15:8] : old[15:8], m[0] ? d[7:0] : old[7:0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        lvbl = 1'b1;
        forever begin
            repeat (FRAME / 2) @(posedge clk);
            lvbl <= ~lvbl;
        end
    end

    initial begin
        #(N_TESTS * WORST_TX * 2 * PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // Bank model: ack after 1..3 cycles, then dst and rdy after 1..3 more
    int        bstate = 0;
    int        bwait = 0;
    bank_req_t bcur;
    always @(posedge clk) begin
        logic [31:0] r;
        r = $random(seed);
        bank_rsp <= '0;
        if (prst) begin
            bstate <= 0;
        end else begin
            case (bstate)
                0: if (bank_req.rd || bank_req.wr) begin
                    bwait  <= 1 + int'(r[1:0] % 2'd3);
                    bstate <= 1;
                end
                1: if (!(bank_req.rd || bank_req.wr)) begin
                    bstate <= 0;
                end else if (bwait <= 1 && !bank_hold) begin
                    bank_rsp.ack <= 1'b1;
                    bcur = bank_req;
                    if (bcur.wr) begin
                        mem[bcur.addr] = merge(mem_read(bcur.addr), bcur.din, bcur.din_m);
                    end else begin
                        seen_rd[bcur.addr] = 1'b1;
                    end
                    bwait  <= 1 + int'(r[3:2] % 2'd3);
                    bstate <= 2;
                end else if (bwait > 1) begin
                    bwait <= bwait - 1;
                end
                2: if (bwait <= 1) begin
                    bank_rsp.rdy <= 1'b1;
                    bank_rsp.dst <= bcur.rd;
                    data_read    <= mem_read(bcur.addr);
                    bstate       <= 3;
                end else begin
                    bwait <= bwait - 1;
                end
                default: bstate <= 0;
            endcase
        end
    end

    // Game model, one request at a time, checks its own responses
    int          gstate = 0;
    sdram_data_t g_exp;
    always @(posedge clk) begin
        logic [31:0] r;
        r = $random(seed);
        if (!prst) begin
            case (gstate)
                0: begin
                    assert (game_rsp == '0) else fail("game response without a request");
                    if (game_en && r[1:0] == 2'd0) begin
                        game_req <= {6'd0, r[15:0], r[16], !r[16], r[31:16], r[18:17]};
                        gstate   <= 1;
                    end
                end
                1: begin
                    assert (!game_rsp.dst && !game_rsp.rdy) else fail("game dst/rdy before ack");
                    if (game_rsp.ack) begin
                        g_exp       = mem_read(game_req.addr);
                        game_req.rd <= 1'b0;
                        game_req.wr <= 1'b0;
                        gstate      <= 2;
                    end
                end
                default: begin
                    assert (!game_rsp.ack) else fail("second ack for one game request");
                    if (game_rsp.dst) begin
                        assert (data_read == g_exp) else fail("game read data mismatch");
                    end
                    if (game_rsp.rdy) begin
                        gstate <= 0;
                    end
                end
            endcase
        end
    end

    // Game first when both ask in the same idle cycle
    logic        both_prev = 1'b0;
    sdram_addr_t game_prev;
    always @(posedge clk) begin
        if (both_prev) begin
            assert ((bank_req.rd || bank_req.wr) && bank_req.addr == game_prev)
                else fail("host served before game");
        end
        both_prev <= !prst && uut.u_arb.state == ARB_IDLE && (game_req.rd || game_req.wr)
                     && (uut.host_req.rd || uut.host_req.wr);
        game_prev <= game_req.addr;
    end

    task automatic apb_write(input port_addr_t a, input port_data_t d);
        @(posedge clk);
        paddr   <= a;
        pwdata  <= d;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input port_addr_t a, output port_data_t d);
        @(posedge clk);
        paddr   <= a;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        d = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input port_addr_t a, input port_data_t exp);
        port_data_t d;
        apb_read(a, d);
        assert (d == exp) else fail($sformatf("reg %02h read %02h, want %02h", a, d, exp));
    endtask

    task automatic wait_idle();
        port_data_t st;
        int polls;
        polls = 0;
        do begin
            apb_read(`REG_RD_GO, st);
            polls++;
            assert (polls < 200) else fail("host transaction never completed");
        end while (st[6]);
    endtask

    task automatic host_access(input logic is_wr);
        logic [31:0] r;
        sdram_addr_t a;
        sdram_data_t d;
        sdram_data_t exp;
        sdram_mask_t m;
        r = $random(seed);
        a = {1'b1, 13'd0, r[7:0]};
        d = r[31:16];
        m = r[9:8];
        apb_write(`REG_KICK, 8'h00);
        apb_write(`REG_ADDR0, a[7:0]);
        apb_write(`REG_ADDR1, a[15:8]);
        apb_write(`REG_ADDR2, {2'b00, a[21:16]});
        apb_write(`REG_WDATA0, d[7:0]);
        apb_write(`REG_WDATA1, d[15:8]);
        apb_write(`REG_MASK, {6'd0, m});
        exp = is_wr ? merge(mem_read(a), d, m) : mem_read(a);
        seen_rd.delete();
        apb_write(is_wr ? `REG_WR_GO : `REG_RD_GO, 8'h00);
        wait_idle();
        if (is_wr) begin
            assert (mem_read(a) == exp) else fail("host write left wrong memory value");
        end else begin
            assert (seen_rd.exists(a)) else fail("bank never saw the host read address");
            check_reg(`REG_RDATA0, exp[7:0]);
            check_reg(`REG_RDATA1, exp[15:8]);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        port_data_t  st;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        flags = '0;
        prst = 1'b1;
        repeat (5) @(posedge clk);
        prst <= 1'b0;

        for (int i = 0; i < N_REG; i++) begin
            r = $random(seed);
            flags <= $random(seed);
            apb_write(`REG_KICK, 8'h00);
            apb_write(`REG_ADDR0 + port_addr_t'(i % 6), r[7:0]);
            check_reg(`REG_ADDR0 + port_addr_t'(i % 6), (i % 6 == 5) ? {6'd0, r[1:0]} : r[7:0]);
            apb_write(`REG_LED, r[15:8]);
            @(negedge clk);
            assert (led == r[8]) else fail("led does not follow bit 0");
            check_reg(`REG_LED, {7'd0, r[8]});
            check_reg(`REG_FLAGS0 + port_addr_t'(i % 4), flags[(i % 4) * 8 +: 8]);
        end

        game_en <= 1'b1;
        for (int i = 0; i < N_HOST; i++) begin
            r = $random(seed);
            host_access(r[0]);
        end
        game_en <= 1'b0;
        wait (gstate == 0 && uut.u_arb.state == ARB_IDLE);

        apb_write(`REG_LED, 8'h01);
        repeat (`CHEAT_WDOG_FRAMES + 4) begin
            @(negedge lvbl);
            apb_write(`REG_KICK, 8'h00);
        end
        assert (led) else fail("led cleared although the host kicked every frame");

        // Stall the bank so the host request stays pending until the trip
        bank_hold <= 1'b1;
        apb_write(`REG_RD_GO, 8'h00);
        n = 0;
        while (!bank_req.rd && n < 50) begin
            @(posedge clk);
            n++;
        end
        assert (bank_req.rd) else fail("host read never reached the bank");
        apb_read(`REG_RD_GO, st);
        assert (st[7:6] == 2'b11) else fail("status does not show the pending host read");
        n = 0;
        while (bank_req.rd && n < (`CHEAT_WDOG_FRAMES + 2) * FRAME) begin
            @(posedge clk);
            n++;
        end
        assert (!bank_req.rd) else fail("watchdog did not drop the pending host request");
        assert (n >= (`CHEAT_WDOG_FRAMES - 1) * FRAME)
            else fail("watchdog dropped the host request too early");
        apb_read(`REG_RD_GO, st);
        assert (st[7:6] == 2'b00) else fail("status still busy after the watchdog trip");
        check_reg(`REG_LED, 8'h00);
        bank_hold <= 1'b0;

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/cheat_pkg.sv
hdl/cheat_regs.sv
hdl/vblank_watchdog.sv
hdl/sdram_arbiter.sv
hdl/cheat_top.sv
test/cheat_properties.sv
test/cheat_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cheat engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cheat_tb -o cheat_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/cheat_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
